// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int INDEX_WIDTH     = 5;
    localparam int OFFSET_WIDTH    = 5;
    localparam int WORD_BITS       = OFFSET_WIDTH - 2;
    localparam int LINE_WORDS      = 1 << WORD_BITS;
    localparam int TAG_WIDTH       = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int SET_NUM         = 1 << INDEX_WIDTH;
    localparam int LINE_ADDR_WIDTH = TAG_WIDTH + INDEX_WIDTH;  // tag and index, 27 bits

    // two ways only, replacement relies on one lru bit per set
    localparam int WAY_NUM = 2;

    // cpu byte address split into cache fields
    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
        logic [WORD_BITS-1:0]   word;
        logic [1:0]             byte_off;
    } fetch_addr_t;

    // answer from the core to the fetch port
    typedef struct packed {
        logic [31:0] word1;
        logic [31:0] word2;
        logic        has_second;  // low for the last word of a line
    } fetch_rsp_t;

    // one accepted read beat of a line fill
    typedef struct packed {
        logic [31:0]          data;
        logic [WORD_BITS-1:0] idx;
        logic                 last;
    } refill_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: fetch_port.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_port (
    input  wire                      clk,
    input  wire                      rst,

    // cpu side
    input  wire                      cpu_req,
    input  wire [31:0]               cpu_addr,
    output logic                     addr_ok,
    output logic                     data_ok1,
    output logic                     data_ok2,
    output logic [31:0]              rdata1,
    output logic [31:0]              rdata2,

    // core side
    output logic                     lookup_valid,
    output icache_pkg::fetch_addr_t  lookup_addr,
    input  wire                      rsp_valid,
    input  wire icache_pkg::fetch_rsp_t rsp
);
    import icache_pkg::*;

    logic busy;  // one fetch in flight

    // accept straight away when nothing is outstanding
    assign addr_ok = cpu_req && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            lookup_valid <= 1'b0;
            data_ok1     <= 1'b0;
            data_ok2     <= 1'b0;
        end else begin
            lookup_valid <= addr_ok;
            data_ok1     <= rsp_valid;
            data_ok2     <= rsp_valid && rsp.has_second;

            if (addr_ok) begin
                busy <= 1'b1;
            end else if (data_ok1) begin
                busy <= 1'b0;  // response has reached the cpu
            end
        end
    end

    // cpu may change its address after addr_ok, keep our own copy
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            lookup_addr <= fetch_addr_t'(cpu_addr);
        end
    end

    // response words, held until the next answer
    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            rdata1 <= rsp.word1;
            rdata2 <= rsp.has_second ? rsp.word2 : 32'd0;
        end
    end

endmodule

`default_nettype wire

// File: icache_core.sv
`timescale 1ns/100ps
`default_nettype none

module icache_core (
    input  wire                        clk,
    input  wire                        rst,

    // from fetch port
    input  wire                        lookup_valid,
    input  wire icache_pkg::fetch_addr_t lookup_addr,
    output logic                       rsp_valid,
    output icache_pkg::fetch_rsp_t     rsp,

    // line fill through the burst reader
    output logic                       refill_req,
    output logic [icache_pkg::LINE_ADDR_WIDTH-1:0] refill_line,
    input  wire                        beat_valid,
    input  wire icache_pkg::refill_beat_t beat,
    input  wire                        refill_done
);
    import icache_pkg::*;

    ctrl_state_e state;
    fetch_addr_t req_q;  // fetch being served

    // storage
    logic [WAY_NUM-1:0][SET_NUM-1:0] valid;
    logic [SET_NUM-1:0]              lru;  // most recently used way per set
    logic [TAG_WIDTH-1:0]            tags  [WAY_NUM][SET_NUM];
    logic [31:0]                     lines [WAY_NUM][SET_NUM][LINE_WORDS];

    logic [WAY_NUM-1:0]   way_hit;
    logic                 hit;
    logic                 hit_way;
    logic                 victim_q;  // way being filled on a miss
    logic                 rd_way;
    logic                 has_second;
    logic [WORD_BITS-1:0] next_word;

    // tag compare against the saved fetch
    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            way_hit[w] = valid[w][req_q.index] && (tags[w][req_q.index] == req_q.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            valid    <= '0;
            lru      <= '0;
            victim_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (lookup_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        lru[req_q.index] <= hit_way;
                        state            <= IDLE;
                    end else begin
                        victim_q <= !lru[req_q.index];  // least recently used way
                        state    <= REFILL;
                    end
                end
                REFILL: begin
                    if (beat_valid && beat.last) begin
                        valid[victim_q][req_q.index] <= 1'b1;
                        lru[req_q.index]             <= victim_q;
                    end
                    if (refill_done) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address of the fetch, taken as the core leaves idle
    always_ff @(posedge clk) begin
        if (state == IDLE && lookup_valid) begin
            req_q <= lookup_addr;
        end
    end

    // each beat goes straight into the victim line
    always_ff @(posedge clk) begin
        if (state == REFILL && beat_valid) begin
            lines[victim_q][req_q.index][beat.idx] <= beat.data;
            if (beat.last) begin
                tags[victim_q][req_q.index] <= req_q.tag;
            end
        end
    end

    assign refill_req  = (state == REFILL);
    assign refill_line = {req_q.tag, req_q.index};

    // read the hit way, or the freshly filled one after a miss
    assign rd_way     = (state == RESPOND) ? victim_q : hit_way;
    assign next_word  = req_q.word + 1'b1;
    assign has_second = (req_q.word != WORD_BITS'(LINE_WORDS - 1));

    assign rsp_valid = ((state == LOOKUP) && hit) || (state == RESPOND);

    always_comb begin
        rsp.word1      = lines[rd_way][req_q.index][req_q.word];
        rsp.word2      = has_second ? lines[rd_way][req_q.index][next_word] : 32'd0;
        rsp.has_second = has_second;
    end

endmodule

`default_nettype wire

// File: burst_reader.sv
`timescale 1ns/100ps
`default_nettype none

module burst_reader (
    input  wire                        clk,
    input  wire                        rst,

    // request from the core
    input  wire                        refill_req,
    input  wire [icache_pkg::LINE_ADDR_WIDTH-1:0] refill_line,
    output logic                       beat_valid,
    output icache_pkg::refill_beat_t   beat,
    output logic                       refill_done,

    // read address channel
    output logic [31:0]                araddr,
    output logic [3:0]                 arlen,
    output logic                       arvalid,
    input  wire                        arready,

    // read data channel
    input  wire [31:0]                 rdata,
    input  wire                        rlast,
    input  wire                        rvalid,
    output logic                       rready
);
    import icache_pkg::*;

    logic                 addr_pend;   // address phase
    logic                 data_phase;  // address taken, beats coming
    logic [WORD_BITS-1:0] beat_cnt;
    logic                 addr_hs;
    logic                 data_hs;

    assign addr_hs = arvalid && arready;
    assign data_hs = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_pend  <= 1'b0;
            data_phase <= 1'b0;
        end else begin
            // refill_req is still high in the rlast cycle, data_phase blocks a restart
            if (refill_req && !addr_pend && !data_phase) begin
                addr_pend <= 1'b1;
            end else if (addr_hs) begin
                addr_pend <= 1'b0;
            end

            if (addr_hs) begin
                data_phase <= 1'b1;
            end else if (data_hs && rlast) begin
                data_phase <= 1'b0;
            end
        end
    end

    // word position of the next beat
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (data_hs) begin
            beat_cnt <= rlast ? '0 : beat_cnt + 1'b1;
        end
    end

    assign araddr  = {refill_line, {OFFSET_WIDTH{1'b0}}};  // line aligned
    assign arlen   = 4'(LINE_WORDS - 1);
    assign arvalid = addr_pend;
    assign rready  = data_phase;

    // beats go to the core in the cycle they are accepted
    assign beat_valid  = data_hs;
    assign refill_done = data_hs && rlast;

    always_comb begin
        beat.data = rdata;
        beat.idx  = beat_cnt;
        beat.last = rlast;
    end

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top (
    input  wire         clk,
    input  wire         rst,

    // cpu fetch port
    input  wire         cpu_req,
    input  wire [31:0]  cpu_addr,
    output wire         addr_ok,
    output wire         data_ok1,
    output wire         data_ok2,
    output wire [31:0]  rdata1,
    output wire [31:0]  rdata2,

    // memory bus
    output wire [31:0]  araddr,
    output wire [3:0]   arlen,
    output wire         arvalid,
    input  wire         arready,
    input  wire [31:0]  rdata,
    input  wire         rlast,
    input  wire         rvalid,
    output wire         rready
);
    import icache_pkg::*;

    logic                       lookup_valid;
    fetch_addr_t                lookup_addr;
    logic                       rsp_valid;
    fetch_rsp_t                 rsp;
    logic                       refill_req;
    logic [LINE_ADDR_WIDTH-1:0] refill_line;
    logic                       beat_valid;
    refill_beat_t               beat;
    logic                       refill_done;

    fetch_port i_fetch_port (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .addr_ok      (addr_ok),
        .data_ok1     (data_ok1),
        .data_ok2     (data_ok2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

    icache_core i_icache_core (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .refill_req   (refill_req),
        .refill_line  (refill_line),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .refill_done  (refill_done)
    );

    burst_reader i_burst_reader (
        .clk          (clk),
        .rst          (rst),
        .refill_req   (refill_req),
        .refill_line  (refill_line),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .refill_done  (refill_done),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready)
    );

endmodule

`default_nettype wire

// File: icache_assert.sv
`timescale 1ns/100ps
`default_nettype none

module icache_assert (
    input wire        clk,
    input wire        rst,
    input wire        arvalid,
    input wire        arready,
    input wire [31:0] araddr,
    input wire        rvalid,
    input wire        rready,
    input wire        rlast,
    input wire        addr_ok,
    input wire        data_ok1
);
    logic        ar_stalled;  // address offered but not taken
    logic [31:0] araddr_q;
    logic        burst_open;
    logic        fetch_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_stalled <= 1'b0;
            burst_open <= 1'b0;
            fetch_open <= 1'b0;
        end else begin
            ar_stalled <= arvalid && !arready;
            araddr_q   <= araddr;
            burst_open <= (arvalid && arready) || (burst_open && !(rvalid && rready && rlast));
            fetch_open <= addr_ok || (fetch_open && !data_ok1);
        end
    end

    arvalid_held: assert property (@(posedge clk) disable iff (rst)
        ar_stalled |-> (arvalid && araddr == araddr_q))
        else $error("arvalid dropped or araddr moved before arready");

    rready_after_addr: assert property (@(posedge clk) disable iff (rst)
        rready |-> burst_open)
        else $error("rready high without an address handshake");

    data_after_accept: assert property (@(posedge clk) disable iff (rst)
        data_ok1 |-> fetch_open)
        else $error("data_ok1 high without an accepted fetch");

endmodule

bind icache_top icache_assert i_icache_assert (.*);

`default_nettype wire

// File: tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_FETCHES    = 400;
    localparam int TIMEOUT_CYCLES = (NUM_FETCHES + 6) * 60;  // one slow refill per fetch

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        cpu_req = 1'b0;
    logic [31:0] cpu_addr = 32'd0;
    logic        arready = 1'b0;
    logic        rvalid = 1'b0;
    logic        rlast = 1'b0;
    logic [31:0] rdata = 32'd0;
    logic        addr_ok;
    logic        data_ok1;
    logic        data_ok2;
    logic        arvalid;
    logic        rready;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] araddr;
    logic [3:0]  arlen;

    int          cycle = 0;
    int          errors = 0;
    int          ar_count = 0;
    int          bursts_done = 0;
    logic [31:0] last_araddr = 32'd0;
    logic [3:0]  last_arlen = 4'd0;

    // memory responder
    logic [31:0] stall_seed = ~32'h3f7b;
    logic        ar_fire = 1'b0;
    logic        r_fire = 1'b0;
    logic        in_burst = 1'b0;
    int          beat_n = 0;
    logic [31:0] burst_base = 32'd0;

    // reference cache, mru way per set
    logic [TAG_WIDTH-1:0] m_tag   [WAY_NUM][SET_NUM];
    logic                 m_valid [WAY_NUM][SET_NUM] = '{default: 1'b0};
    logic                 m_mru   [SET_NUM] = '{default: 1'b0};

    icache_top i_icache_top (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory content is a hash of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %s got %h exp %h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("error at cycle %0d, %s", cycle, msg);
        errors++;
    endtask

    // two-way lru lookup and fill
    task automatic model_access(input logic [31:0] addr, output logic hit,
                                output logic [TAG_WIDTH-1:0] old_tag);
        fetch_addr_t f;
        logic        way;
        f   = fetch_addr_t'(addr);
        hit = 1'b0;
        way = !m_mru[f.index];
        for (int w = 0; w < WAY_NUM; w++) begin
            if (m_valid[w][f.index] && m_tag[w][f.index] == f.tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        old_tag = m_tag[way][f.index];
        m_valid[way][f.index] = 1'b1;
        m_tag[way][f.index]   = f.tag;
        m_mru[f.index]        = way;
    endtask

    // sample the bus mid-cycle
    always @(negedge clk) begin
        ar_fire = arvalid && arready;
        r_fire  = rvalid && rready;
        if (ar_fire) begin
            last_araddr = araddr;
            last_arlen  = arlen;
        end
    end

    always @(posedge clk) begin
        logic        active;
        logic [31:0] base;
        int          n;
        stall_seed = lcg_next(stall_seed);
        active     = in_burst;
        base       = burst_base;
        n          = beat_n;
        if (ar_fire) begin
            ar_count <= ar_count + 1;
            active = 1'b1;
            base   = last_araddr;
            n      = 0;
        end
        if (r_fire) begin
            n = n + 1;
            if (rlast) begin
                bursts_done <= bursts_done + 1;
                active = 1'b0;
            end
        end
        arready    <= !rst && (stall_seed[31:30] != 2'b00);  // stall about a quarter
        rvalid     <= !rst && active && (stall_seed[29:28] != 2'b00);
        rlast      <= (n == LINE_WORDS - 1);
        rdata      <= mem_word(base + 32'(n) * 32'd4);
        in_burst   <= active;
        burst_base <= base;
        beat_n     <= n;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic do_fetch(input logic [31:0] addr, output logic [TAG_WIDTH-1:0] old_tag);
        fetch_addr_t f;
        logic        hit;
        int          ar_before;
        int          bursts_before;
        int          t_accept;
        f = fetch_addr_t'(addr);
        model_access(addr, hit, old_tag);
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_addr <= addr;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        t_accept      = cycle;
        ar_before     = ar_count;
        bursts_before = bursts_done;
        @(posedge clk);
        cpu_req  <= 1'b0;
        cpu_addr <= ~addr;  // port keeps its own copy
        @(negedge clk);
        while (!data_ok1) @(negedge clk);
        if (rdata1 !== mem_word(addr)) report_mismatch("rdata1", rdata1, mem_word(addr));
        if (f.word != WORD_BITS'(LINE_WORDS - 1)) begin
            if (data_ok2 !== 1'b1) report_mismatch("data_ok2", 32'(data_ok2), 32'd1);
            if (rdata2 !== mem_word(addr + 32'd4)) begin
                report_mismatch("rdata2", rdata2, mem_word(addr + 32'd4));
            end
        end else begin
            if (data_ok2 !== 1'b0) report_mismatch("data_ok2", 32'(data_ok2), 32'd0);
            if (rdata2 !== 32'd0) report_mismatch("rdata2", rdata2, 32'd0);
        end
        if (hit) begin
            if (ar_count != ar_before) report_problem("a predicted hit started a bus read");
            if (cycle - t_accept != 3) begin
                report_mismatch("hit latency", 32'(cycle - t_accept), 32'd3);
            end
        end else begin
            if (ar_count - ar_before != 1) begin
                report_mismatch("address handshakes", 32'(ar_count - ar_before), 32'd1);
            end
            if (last_araddr !== {addr[31:5], 5'd0}) begin
                report_mismatch("araddr", last_araddr, {addr[31:5], 5'd0});
            end
            if (last_arlen !== 4'd7) report_mismatch("arlen", 32'(last_arlen), 32'd7);
            if (bursts_done - bursts_before != 1) report_problem("the line fill did not complete");
        end
    endtask

    initial begin
        logic [TAG_WIDTH-1:0] old_tag;
        logic [31:0]          seed;
        int                   ar_before;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (addr_ok || data_ok1 || arvalid || rready) begin
                report_problem("a handshake went high after reset with no fetch");
            end
        end

        // three tags on set 7
        do_fetch({22'h00100, 5'd7, 5'd8}, old_tag);
        do_fetch({22'h00200, 5'd7, 5'd12}, old_tag);
        do_fetch({22'h00100, 5'd7, 5'd28}, old_tag);  // second tag now least recent
        do_fetch({22'h00300, 5'd7, 5'd0}, old_tag);
        ar_before = ar_count;
        do_fetch({old_tag, 5'd7, 5'd4}, old_tag);
        if (ar_count != ar_before + 1) report_problem("the evicted line came back without a burst");
        do_fetch({22'h00300, 5'd7, 5'd16}, old_tag);

        // random fetches over a 4 KB window
        seed = 32'h3f7b;
        for (int i = 0; i < NUM_FETCHES; i++) begin
            seed = lcg_next(seed);
            do_fetch({20'h00040, seed[27:18], 2'b00}, old_tag);
        end
        @(negedge clk);
        if (ar_count != bursts_done) report_problem("a burst was left open at the end");
        $display("%0d bus bursts, %0d errors", bursts_done, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
icache_pkg.sv
fetch_port.sv
icache_core.sv
burst_reader.sv
icache_top.sv
icache_assert.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_icache -f all.f -o sim_icache &&
./obj_dir/sim_icache | grep "TEST PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
